/* include/lsu_cfg.svh */
// ========================================
// LSU configuration macros
// Data path widths, model response latency
// and physical memory region bounds
// ========================================

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Widths
`define LSU_PADDR_W      32
`define LSU_XLEN         64
`define LSU_PREG_W       6
`define LSU_ROB_W        5

// Cycles from accepted request to response pulse (cache model)
`define LSU_RSP_LAT      2

// Region map with exclusive end bounds
// Only DRAM is cacheable
`define LSU_DRAM_START   32'h8000_0000
`define LSU_DRAM_END     32'h9000_0000
`define LSU_UART_START   32'h1000_0000
`define LSU_UART_END     32'h1000_1000
`define LSU_CLINT_START  32'h0200_0000
`define LSU_CLINT_END    32'h0201_0000
`define LSU_ROM_START    32'h0000_1000
`define LSU_ROM_END      32'h0001_0000

`endif

/* design/lsu_pkg.sv */
// ========================================
// LSU shared types
// Vector typedefs, access size and opcode
// enums, request/response/commit structs
// ========================================

`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_PADDR_W-1:0]  paddr_t;
    typedef logic [`LSU_XLEN-1:0]     xdata_t;
    typedef logic [`LSU_PREG_W-1:0]   preg_idx_t;
    typedef logic [`LSU_ROB_W-1:0]    rob_idx_t;
    typedef logic [`LSU_XLEN/8-1:0]   byte_en_t;
    typedef logic [2:0]               byte_off_t;

    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_HALF  = 2'd1,
        SIZE_WORD  = 2'd2,
        SIZE_DWORD = 2'd3
    } mem_size_e;

    typedef enum logic [2:0] {
        MEM_OP_LOAD  = 3'd0,
        MEM_OP_LD_FP = 3'd1,
        MEM_OP_STORE = 3'd2,
        MEM_OP_ST_FP = 3'd3,
        MEM_OP_FENCE = 3'd4
    } mem_op_e;

    // ========================================
    // Issue, cache and commit buses
    // ========================================

    typedef struct packed {
        paddr_t     paddr;
        xdata_t     wdata;
        preg_idx_t  rdst_idx;
        logic       rdst_is_fp;
        mem_size_e  size;
        mem_op_e    mem_op;
        rob_idx_t   rob_idx;
        logic       sign_ext;
    } lsu_issue_t;

    // wdata is already aligned to the byte lanes of be
    typedef struct packed {
        paddr_t     paddr;
        xdata_t     wdata;
        byte_en_t   be;
        mem_size_e  size;
        logic       is_load;
        logic       is_store;
        logic       cacheable;
        rob_idx_t   rob_idx;
        preg_idx_t  rdst_idx;
        logic       rdst_is_fp;
        logic       sign_ext;
    } dcache_req_t;

    typedef struct packed {
        logic       valid;
        xdata_t     rdata;
        byte_off_t  offset;
        mem_size_e  size;
        logic       sign_ext;
        logic       is_load;
        logic       is_store;
        logic       cacheable;
        rob_idx_t   rob_idx;
        preg_idx_t  rdst_idx;
        logic       rdst_is_fp;
    } dcache_rsp_t;

    typedef struct packed {
        logic       we;
        preg_idx_t  idx;
        xdata_t     data;
    } reg_wb_t;

    typedef struct packed {
        logic       vld;
        preg_idx_t  idx;
        logic       is_fp;
    } awake_t;

    typedef struct packed {
        logic       vld;
        rob_idx_t   idx;
    } rob_commit_t;

endpackage

`default_nettype wire

/* design/lsu_issue_stage.sv */
// ========================================
// LSU issue stage
// Stage 1 register, opcode decode, region
// check, stall and non-cacheable lock,
// byte enables and data cache request
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_issue_stage
    import lsu_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         flush_i,
    // Issue port
    input  wire logic         issue_vld_i,
    input  wire lsu_issue_t   issue_req_i,
    output      logic         issue_rdy_o,
    // Data cache
    output      logic         dcache_req_vld_o,
    output      dcache_req_t  dcache_req_o,
    input  wire logic         dcache_rdy_i,
    input  wire dcache_rsp_t  dcache_rsp_i,
    input  wire logic         dcache_idle_i,
    // Direct fence commit
    output      logic         fence_commit_o,
    output      rob_idx_t     fence_rob_idx_o
);

    logic        st1_vld_q;
    lsu_issue_t  st1_q;
    logic        st1_act;
    logic        st1_stall;
    logic        st1_leave;
    logic        nc_lock_q;

    logic        is_load;
    logic        is_store;
    logic        is_fence;
    logic        in_dram;
    logic        in_uart;
    logic        in_clint;
    logic        in_rom;
    logic        addr_legal;
    logic        cacheable;

    byte_off_t   offset;
    byte_en_t    st1_be;
    xdata_t      st1_wdata_sh;

    // ========================================
    // Stage 1 register
    // ========================================

    // Flush kills the held operation in the same cycle
    assign st1_act     = st1_vld_q && !flush_i;
    assign st1_leave   = st1_act && !st1_stall;
    assign issue_rdy_o = !st1_act || st1_leave;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st1_vld_q <= 1'b0;
        end else begin
            st1_vld_q <= issue_rdy_o ? issue_vld_i : st1_act;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_vld_i && issue_rdy_o) begin
            st1_q <= issue_req_i;
        end
    end

    // ========================================
    // Decode and region map
    // ========================================

    assign is_load  = (st1_q.mem_op == MEM_OP_LOAD)  || (st1_q.mem_op == MEM_OP_LD_FP);
    assign is_store = (st1_q.mem_op == MEM_OP_STORE) || (st1_q.mem_op == MEM_OP_ST_FP);
    assign is_fence = (st1_q.mem_op == MEM_OP_FENCE);

    assign in_dram  = (st1_q.paddr >= `LSU_DRAM_START)  && (st1_q.paddr < `LSU_DRAM_END);
    assign in_uart  = (st1_q.paddr >= `LSU_UART_START)  && (st1_q.paddr < `LSU_UART_END);
    assign in_clint = (st1_q.paddr >= `LSU_CLINT_START) && (st1_q.paddr < `LSU_CLINT_END);
    assign in_rom   = (st1_q.paddr >= `LSU_ROM_START)   && (st1_q.paddr < `LSU_ROM_END);

    assign addr_legal = in_dram || in_uart || in_clint || in_rom;
    assign cacheable  = in_dram;

    // ========================================
    // Stall, lock and cache request
    // ========================================

    always_comb begin
        st1_stall = 1'b0;
        if (nc_lock_q) begin
            st1_stall = 1'b1;
        end
        if (is_fence) begin
            // Fence needs an idle cache and a free commit bus
            if (!dcache_idle_i || dcache_rsp_i.valid) begin
                st1_stall = 1'b1;
            end
        end else begin
            // Illegal address waits here until a flush
            if (!addr_legal) begin
                st1_stall = 1'b1;
            end
            if (!cacheable && !dcache_idle_i) begin
                st1_stall = 1'b1;
            end
            if (!dcache_rdy_i) begin
                st1_stall = 1'b1;
            end
        end
    end

    assign dcache_req_vld_o = st1_act && !is_fence && addr_legal && !nc_lock_q
                              && (cacheable || dcache_idle_i);

    // Set by a non-cacheable handshake and cleared by its response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            nc_lock_q <= 1'b0;
        end else if (flush_i) begin
            nc_lock_q <= 1'b0;
        end else if (dcache_req_vld_o && dcache_rdy_i && !cacheable) begin
            nc_lock_q <= 1'b1;
        end else if (dcache_rsp_i.valid && !dcache_rsp_i.cacheable) begin
            nc_lock_q <= 1'b0;
        end
    end

    assign fence_commit_o  = st1_leave && is_fence;
    assign fence_rob_idx_o = st1_q.rob_idx;

    // Byte lanes and store data alignment
    assign offset = st1_q.paddr[2:0];

    always_comb begin
        case (st1_q.size)
            SIZE_BYTE: st1_be = byte_en_t'(8'h01 << offset);
            SIZE_HALF: st1_be = byte_en_t'(8'h03 << offset);
            SIZE_WORD: st1_be = byte_en_t'(8'h0f << offset);
            default:   st1_be = 8'hff;
        endcase
    end

    assign st1_wdata_sh = st1_q.wdata << {offset, 3'b000};

    always_comb begin
        dcache_req_o.paddr      = st1_q.paddr;
        dcache_req_o.wdata      = st1_wdata_sh;
        dcache_req_o.be         = st1_be;
        dcache_req_o.size       = st1_q.size;
        dcache_req_o.is_load    = is_load;
        dcache_req_o.is_store   = is_store;
        dcache_req_o.cacheable  = cacheable;
        dcache_req_o.rob_idx    = st1_q.rob_idx;
        dcache_req_o.rdst_idx   = st1_q.rdst_idx;
        dcache_req_o.rdst_is_fp = st1_q.rdst_is_fp;
        dcache_req_o.sign_ext   = st1_q.sign_ext;
    end

endmodule

`default_nettype wire

/* design/lsu_load_align.sv */
// ========================================
// LSU load aligner
// Shifts returned load data to bit 0,
// extends by size and NaN-boxes FP words
// ========================================

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
    import lsu_pkg::*;
(
    input  wire dcache_rsp_t  rsp_i,
    output      xdata_t       load_data_o
);

    xdata_t  rdata_sh;
    logic    ext_b;
    logic    ext_h;
    logic    ext_w;

    // Bring the addressed bytes down to lane 0
    assign rdata_sh = rsp_i.rdata >> {rsp_i.offset, 3'b000};

    // Fill bit per size is zero without sign extension
    assign ext_b = rsp_i.sign_ext && rdata_sh[7];
    assign ext_h = rsp_i.sign_ext && rdata_sh[15];
    assign ext_w = rsp_i.sign_ext && rdata_sh[31];

    always_comb begin
        case (rsp_i.size)
            SIZE_BYTE: begin
                load_data_o = {{56{ext_b}}, rdata_sh[7:0]};
            end
            SIZE_HALF: begin
                load_data_o = {{48{ext_h}}, rdata_sh[15:0]};
            end
            SIZE_WORD: begin
                // Single precision value in an FP register is NaN-boxed
                if (rsp_i.rdst_is_fp && rsp_i.sign_ext) begin
                    load_data_o = {32'hffff_ffff, rdata_sh[31:0]};
                end else begin
                    load_data_o = {{32{ext_w}}, rdata_sh[31:0]};
                end
            end
            default: begin
                load_data_o = rsp_i.rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/lsu_commit_merge.sv */
// ========================================
// LSU commit and write-back merge
// Registered ROB commit, GPR/FPR write-back
// and wake-up of dependent instructions
// ========================================

`timescale 1ns/1ps
`default_nettype none

module lsu_commit_merge
    import lsu_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire dcache_rsp_t  rsp_i,
    input  wire xdata_t       load_data_i,
    input  wire logic         fence_commit_i,
    input  wire rob_idx_t     fence_rob_idx_i,
    output      reg_wb_t      gpr_wb_o,
    output      reg_wb_t      fpr_wb_o,
    output      awake_t       awake_o,
    output      rob_commit_t  rob_commit_o
);

    logic       commit_vld_q;
    rob_idx_t   commit_idx_q;
    logic       gpr_we_q;
    logic       fpr_we_q;
    preg_idx_t  wb_idx_q;
    xdata_t     wb_data_q;

    // Valid bits
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            commit_vld_q <= 1'b0;
            gpr_we_q     <= 1'b0;
            fpr_we_q     <= 1'b0;
        end else begin
            commit_vld_q <= rsp_i.valid || fence_commit_i;
            gpr_we_q     <= rsp_i.valid && rsp_i.is_load && !rsp_i.rdst_is_fp;
            fpr_we_q     <= rsp_i.valid && rsp_i.is_load && rsp_i.rdst_is_fp;
        end
    end

    // Fence never shares a cycle with a response
    always_ff @(posedge clk_i) begin
        commit_idx_q <= fence_commit_i ? fence_rob_idx_i : rsp_i.rob_idx;
        wb_idx_q     <= rsp_i.rdst_idx;
        wb_data_q    <= load_data_i;
    end

    always_comb begin
        rob_commit_o.vld = commit_vld_q;
        rob_commit_o.idx = commit_idx_q;

        gpr_wb_o.we   = gpr_we_q;
        gpr_wb_o.idx  = wb_idx_q;
        gpr_wb_o.data = wb_data_q;

        fpr_wb_o.we   = fpr_we_q;
        fpr_wb_o.idx  = wb_idx_q;
        fpr_wb_o.data = wb_data_q;

        // Wake-up follows the active write-back
        awake_o.vld   = gpr_we_q || fpr_we_q;
        awake_o.idx   = wb_idx_q;
        awake_o.is_fp = fpr_we_q;
    end

endmodule

`default_nettype wire

/* design/lsu_ctrl_top.sv */
// ========================================
// LSU control top level
// Issue stage, load aligner and commit
// merge connected to core and data cache
// ========================================

`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_top
    import lsu_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         flush_i,
    // Issue from the core
    input  wire logic         issue_vld_i,
    input  wire lsu_issue_t   issue_req_i,
    output      logic         issue_rdy_o,
    // Data cache
    output      logic         dcache_req_vld_o,
    output      dcache_req_t  dcache_req_o,
    input  wire logic         dcache_rdy_i,
    input  wire dcache_rsp_t  dcache_rsp_i,
    input  wire logic         dcache_idle_i,
    // Write-back, wake-up and commit
    output      reg_wb_t      gpr_wb_o,
    output      reg_wb_t      fpr_wb_o,
    output      awake_t       awake_o,
    output      rob_commit_t  rob_commit_o
);

    logic      fence_commit;
    rob_idx_t  fence_rob_idx;
    xdata_t    load_wb;

    lsu_issue_stage u_issue_stage (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .issue_vld_i      (issue_vld_i),
        .issue_req_i      (issue_req_i),
        .issue_rdy_o      (issue_rdy_o),
        .dcache_req_vld_o (dcache_req_vld_o),
        .dcache_req_o     (dcache_req_o),
        .dcache_rdy_i     (dcache_rdy_i),
        .dcache_rsp_i     (dcache_rsp_i),
        .dcache_idle_i    (dcache_idle_i),
        .fence_commit_o   (fence_commit),
        .fence_rob_idx_o  (fence_rob_idx)
    );

    lsu_load_align u_load_align (
        .rsp_i       (dcache_rsp_i),
        .load_data_o (load_wb)
    );

    lsu_commit_merge u_commit_merge (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .rsp_i           (dcache_rsp_i),
        .load_data_i     (load_wb),
        .fence_commit_i  (fence_commit),
        .fence_rob_idx_i (fence_rob_idx),
        .gpr_wb_o        (gpr_wb_o),
        .fpr_wb_o        (fpr_wb_o),
        .awake_o         (awake_o),
        .rob_commit_o    (rob_commit_o)
    );

endmodule

`default_nettype wire

/* tests/lsu_dcache_model.sv */
// ========================================
// Behavioral data cache for the LSU tests
// 16 doubleword memory, fixed latency,
// testbench-controlled ready and idle
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_dcache_model
    import lsu_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire logic         req_vld_i,
    input  wire dcache_req_t  req_i,
    output      logic         rdy_o,
    output      dcache_rsp_t  rsp_o,
    output      logic         idle_o,
    input  wire logic         tb_rdy_i,
    input  wire logic         tb_idle_i
);

    xdata_t       mem [16];
    dcache_rsp_t  pipe_q [`LSU_RSP_LAT];
    dcache_rsp_t  rsp_new;
    logic [3:0]   idx;
    logic         busy;

    // Bits 6:3 select the same word in every region
    assign idx    = req_i.paddr[6:3];
    assign rdy_o  = tb_rdy_i && rst_n_i;
    assign rsp_o  = pipe_q[`LSU_RSP_LAT-1];
    assign idle_o = tb_idle_i && !busy;

    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < `LSU_RSP_LAT; i++) begin
            busy = busy || pipe_q[i].valid;
        end
    end

    always_comb begin
        rsp_new.valid      = req_vld_i && rdy_o;
        rsp_new.rdata      = mem[idx];
        rsp_new.offset     = req_i.paddr[2:0];
        rsp_new.size       = req_i.size;
        rsp_new.sign_ext   = req_i.sign_ext;
        rsp_new.is_load    = req_i.is_load;
        rsp_new.is_store   = req_i.is_store;
        rsp_new.cacheable  = req_i.cacheable;
        rsp_new.rob_idx    = req_i.rob_idx;
        rsp_new.rdst_idx   = req_i.rdst_idx;
        rsp_new.rdst_is_fp = req_i.rdst_is_fp;
    end

    // Response delay line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `LSU_RSP_LAT; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= rsp_new;
            for (int i = 1; i < `LSU_RSP_LAT; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    // Reset fill pattern and byte-enabled store writes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= {8{4'(15 - i), 4'(i)}};
            end
        end else if (rsp_new.valid && req_i.is_store) begin
            for (int b = 0; b < 8; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/lsu_ctrl_tb.sv */
// ========================================
// LSU control testbench
// Clock, reset, DUT dut0, cache model and
// directed tests with self-checking
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_cfg.svh"

module lsu_ctrl_tb
    import lsu_pkg::*;
();

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         issue_vld;
    lsu_issue_t   issue_req;
    logic         issue_rdy;
    logic         dcache_req_vld;
    dcache_req_t  dcache_req;
    logic         dcache_rdy;
    dcache_rsp_t  dcache_rsp;
    logic         dcache_idle;
    reg_wb_t      gpr_wb;
    reg_wb_t      fpr_wb;
    awake_t       awake;
    rob_commit_t  rob_commit;
    logic         tb_rdy;
    logic         tb_idle;

    xdata_t       image [16];
    integer       seed;
    rob_idx_t     rob_ctr;

    lsu_ctrl_top dut0 (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .issue_vld_i      (issue_vld),
        .issue_req_i      (issue_req),
        .issue_rdy_o      (issue_rdy),
        .dcache_req_vld_o (dcache_req_vld),
        .dcache_req_o     (dcache_req),
        .dcache_rdy_i     (dcache_rdy),
        .dcache_rsp_i     (dcache_rsp),
        .dcache_idle_i    (dcache_idle),
        .gpr_wb_o         (gpr_wb),
        .fpr_wb_o         (fpr_wb),
        .awake_o          (awake),
        .rob_commit_o     (rob_commit)
    );

    lsu_dcache_model u_dcache (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .req_vld_i (dcache_req_vld),
        .req_i     (dcache_req),
        .rdy_o     (dcache_rdy),
        .rsp_o     (dcache_rsp),
        .idle_o    (dcache_idle),
        .tb_rdy_i  (tb_rdy),
        .tb_idle_i (tb_idle)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Expected write-back value from the tracked memory image
    function automatic xdata_t load_expect(input lsu_issue_t r);
        xdata_t dw;
        xdata_t v;
        int     off;
        int     n;
        dw  = image[r.paddr[6:3]];
        off = r.paddr[2:0];
        n   = 1 << r.size;
        v   = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = dw[8*(off + i) +: 8];
        end
        if (r.sign_ext && n < 8 && v[8*n-1]) begin
            for (int i = n; i < 8; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        if (r.rdst_is_fp && r.sign_ext && r.size == SIZE_WORD) begin
            v[63:32] = 32'hffff_ffff;
        end
        return v;
    endfunction

    task automatic make_load(input paddr_t a, input mem_size_e s, input logic sx,
                             input logic fp, output lsu_issue_t r);
        logic [31:0] rnd;
        rnd          = rand32();
        r            = '0;
        r.paddr      = a;
        r.size       = s;
        r.sign_ext   = sx;
        r.rdst_is_fp = fp;
        r.mem_op     = fp ? MEM_OP_LD_FP : MEM_OP_LOAD;
        r.rdst_idx   = rnd[5:0];
        r.rob_idx    = rob_ctr;
        rob_ctr      = rob_ctr + 1'b1;
    endtask

    // Starts and ends on a falling edge and returns after the handshake
    task automatic send_op(input lsu_issue_t r);
        int n;
        n         = 0;
        issue_req = r;
        issue_vld = 1'b1;
        while (!issue_rdy) begin
            @(negedge clk);
            n++;
            if (n > 50) begin
                $display("Timeout: issue port never became ready");
                stop_on_error();
            end
        end
        @(negedge clk);
        issue_vld = 1'b0;
    endtask

    task automatic wait_commit();
        int n;
        n = 0;
        while (!rob_commit.vld) begin
            @(negedge clk);
            n++;
            if (n > 50) begin
                $display("Timeout: no ROB commit arrived");
                stop_on_error();
            end
        end
    endtask

    task automatic verify_load_wb(input lsu_issue_t r);
        reg_wb_t wb;
        reg_wb_t other;
        string   name;
        string   other_name;
        wb         = r.rdst_is_fp ? fpr_wb : gpr_wb;
        other      = r.rdst_is_fp ? gpr_wb : fpr_wb;
        name       = r.rdst_is_fp ? "fpr_wb_o" : "gpr_wb_o";
        other_name = r.rdst_is_fp ? "gpr_wb_o.we" : "fpr_wb_o.we";
        expect_equal("rob_commit_o.idx", rob_commit.idx, r.rob_idx);
        expect_equal({name, ".we"}, wb.we, 1'b1);
        expect_equal({name, ".idx"}, wb.idx, r.rdst_idx);
        expect_equal({name, ".data"}, wb.data, load_expect(r));
        expect_equal(other_name, other.we, 1'b0);
        expect_equal("awake_o.vld", awake.vld, 1'b1);
        expect_equal("awake_o.idx", awake.idx, r.rdst_idx);
        expect_equal("awake_o.is_fp", awake.is_fp, r.rdst_is_fp);
    endtask

    task automatic run_load(input lsu_issue_t r);
        send_op(r);
        wait_commit();
        verify_load_wb(r);
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic reset_state();
        expect_equal("issue_rdy_o", issue_rdy, 1'b1);
        expect_equal("dcache_req_vld_o", dcache_req_vld, 1'b0);
        expect_equal("rob_commit_o.vld", rob_commit.vld, 1'b0);
        expect_equal("gpr_wb_o.we", gpr_wb.we, 1'b0);
        expect_equal("fpr_wb_o.we", fpr_wb.we, 1'b0);
        expect_equal("awake_o.vld", awake.vld, 1'b0);
    endtask

    task automatic store_then_loads(input paddr_t base);
        lsu_issue_t r;
        mem_size_e  s;
        logic [2:0] off;
        r         = '0;
        r.paddr   = base;
        r.wdata   = {rand32(), rand32()};
        r.size    = SIZE_DWORD;
        r.mem_op  = MEM_OP_STORE;
        r.rob_idx = rob_ctr;
        rob_ctr   = rob_ctr + 1'b1;
        send_op(r);
        wait_commit();
        expect_equal("rob_commit_o.idx", rob_commit.idx, r.rob_idx);
        expect_equal("gpr_wb_o.we", gpr_wb.we, 1'b0);
        expect_equal("fpr_wb_o.we", fpr_wb.we, 1'b0);
        image[base[6:3]] = r.wdata;
        for (int k = 0; k < 3; k++) begin
            s = mem_size_e'(k);
            for (int sx = 0; sx < 2; sx++) begin
                // Natural alignment inside the doubleword
                off = rand32() & (8 - (1 << k));
                make_load(base + off, s, sx[0], 1'b0, r);
                run_load(r);
            end
        end
    endtask

    task automatic fp_word_nan_box(input paddr_t base);
        lsu_issue_t r;
        make_load(base + ((rand32() & 1) << 2), SIZE_WORD, 1'b1, 1'b1, r);
        run_load(r);
    endtask

    task automatic cache_backpressure(input paddr_t base);
        lsu_issue_t  r;
        dcache_req_t held;
        byte_en_t    be_exp;
        int          hold;
        make_load(base + ((rand32() & 3) << 1), SIZE_HALF, 1'b1, 1'b0, r);
        tb_rdy = 1'b0;
        send_op(r);
        held = dcache_req;
        // Half access covers the addressed byte and the next one
        be_exp                      = '0;
        be_exp[r.paddr[2:0]]        = 1'b1;
        be_exp[r.paddr[2:0] + 3'd1] = 1'b1;
        expect_equal("dcache_req_vld_o", dcache_req_vld, 1'b1);
        expect_equal("dcache_req_o.paddr", held.paddr, r.paddr);
        expect_equal("dcache_req_o.be", held.be, be_exp);
        expect_equal("dcache_req_o.is_load", held.is_load, 1'b1);
        expect_equal("dcache_req_o.cacheable", held.cacheable, 1'b1);
        hold = 1 + (rand32() & 7);
        repeat (hold) begin
            @(negedge clk);
            expect_equal("dcache_req_vld_o", dcache_req_vld, 1'b1);
            expect_equal("dcache_req_o", dcache_req, held);
            expect_equal("issue_rdy_o", issue_rdy, 1'b0);
        end
        tb_rdy = 1'b1;
        wait_commit();
        verify_load_wb(r);
    endtask

    task automatic uart_lock_and_fence();
        lsu_issue_t ra;
        lsu_issue_t rb;
        lsu_issue_t rf;
        logic       seen_rsp;
        logic       taken;
        int         commits;
        int         n;
        make_load(`LSU_UART_START + 32'h8, SIZE_DWORD, 1'b0, 1'b0, ra);
        make_load(`LSU_UART_START + 32'h14, SIZE_WORD, 1'b1, 1'b0, rb);
        send_op(ra);
        issue_req = rb;
        issue_vld = 1'b1;
        seen_rsp  = 1'b0;
        taken     = 1'b0;
        commits   = 0;
        n         = 0;
        while (commits < 2) begin
            if (issue_vld && issue_rdy) begin
                taken = 1'b1;
            end
            if (dcache_rsp.valid && dcache_rsp.rob_idx == ra.rob_idx) begin
                seen_rsp = 1'b1;
            end
            if (dcache_req_vld && dcache_req.rob_idx == rb.rob_idx) begin
                assert (seen_rsp) else begin
                    $display("Second UART request was sent before the first response");
                    stop_on_error();
                end
            end
            if (rob_commit.vld) begin
                verify_load_wb(commits == 0 ? ra : rb);
                commits++;
            end
            @(negedge clk);
            if (taken) begin
                issue_vld = 1'b0;
            end
            n++;
            if (n > 60) begin
                $display("Timeout: UART loads did not both commit");
                stop_on_error();
            end
        end
        // Fence waits for the cache to go idle
        rf         = '0;
        rf.mem_op  = MEM_OP_FENCE;
        rf.rob_idx = rob_ctr;
        rob_ctr    = rob_ctr + 1'b1;
        tb_idle    = 1'b0;
        send_op(rf);
        repeat (2 + (rand32() & 7)) begin
            expect_equal("rob_commit_o.vld", rob_commit.vld, 1'b0);
            @(negedge clk);
        end
        tb_idle = 1'b1;
        wait_commit();
        expect_equal("rob_commit_o.idx", rob_commit.idx, rf.rob_idx);
        expect_equal("gpr_wb_o.we", gpr_wb.we, 1'b0);
        @(negedge clk);
        expect_equal("rob_commit_o.vld", rob_commit.vld, 1'b0);
    endtask

    task automatic illegal_addr_flush(input paddr_t base);
        lsu_issue_t r;
        make_load(32'h4000_0000, SIZE_DWORD, 1'b0, 1'b0, r);
        send_op(r);
        repeat (6) begin
            expect_equal("dcache_req_vld_o", dcache_req_vld, 1'b0);
            expect_equal("issue_rdy_o", issue_rdy, 1'b0);
            expect_equal("rob_commit_o.vld", rob_commit.vld, 1'b0);
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        expect_equal("issue_rdy_o", issue_rdy, 1'b1);
        make_load(base, SIZE_DWORD, 1'b0, 1'b0, r);
        run_load(r);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        paddr_t base;
        seed      = 32'haec7;
        rob_ctr   = '0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        issue_vld = 1'b0;
        issue_req = '0;
        tb_rdy    = 1'b1;
        tb_idle   = 1'b1;
        // Mirror of the model's reset fill
        for (int i = 0; i < 16; i++) begin
            image[i] = {8{4'(15 - i), 4'(i)}};
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        base  = `LSU_DRAM_START + ((rand32() & 15) << 3);
        reset_state();
        store_then_loads(base);
        fp_word_nan_box(base);
        cache_backpressure(base);
        uart_lock_and_fence();
        illegal_addr_flush(base);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_ctrl.f */
+incdir+include
design/lsu_pkg.sv
design/lsu_issue_stage.sv
design/lsu_load_align.sv
design/lsu_commit_merge.sv
design/lsu_ctrl_top.sv
tests/lsu_dcache_model.sv
tests/lsu_ctrl_tb.sv
